// ==== hdl/arch_map_table.sv ====
module arch_map_table import rename_cfg_pkg::*, rename_if_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        mispredict,	// retire is dropped this cycle
	input  retire_req_t retire,
	output arch_map_t   committed_map,
	output logic [1:0]  free_valid,	// bit per retire slot
	output phys_idx_t   free_tag0,
	output phys_idx_t   free_tag1
);

	arch_map_t    arch_map;	// retirement copy of the alias table
	arch_map_t    arch_map_next;
	retire_slot_t ret0;
	retire_slot_t ret1;
	logic         same_dest;

	assign ret0 = retire[0];
	assign ret1 = retire[1];

	////////////////////////////////////////
	// displaced tags
	////////////////////////////////////////
	assign same_dest = ret0.valid && ret1.valid && (ret0.dest_arch == ret1.dest_arch);

	assign free_valid = mispredict ? 2'b00 : {ret1.valid, ret0.valid};
	assign free_tag0  = arch_map[ret0.dest_arch];
	// slot 1 overwrites what slot 0 just committed
	assign free_tag1  = same_dest ? ret0.dest_phys : arch_map[ret1.dest_arch];

	////////////////////////////////////////
	// commit
	////////////////////////////////////////
	always_comb begin
		arch_map_next = arch_map;
		if (!mispredict) begin
			if (ret0.valid) begin
				arch_map_next[ret0.dest_arch] = ret0.dest_phys;
			end
			if (ret1.valid) begin
				arch_map_next[ret1.dest_arch] = ret1.dest_phys;	// later commit wins
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			arch_map <= identity_map();
		end else begin
			arch_map <= arch_map_next;
		end
	end

	assign committed_map = arch_map;	// visible the cycle after retire

endmodule

// ==== hdl/phys_free_list.sv ====
module phys_free_list import rename_cfg_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  logic       mispredict,	// rebuild from committed_map
	input  logic       alloc_take0,	// consume alloc_tag0
	input  logic       alloc_take1,	// consume alloc_tag1
	output phys_idx_t  alloc_tag0,
	output phys_idx_t  alloc_tag1,
	output logic [1:0] alloc_count,
	input  logic [1:0] free_valid,
	input  phys_idx_t  free_tag0,
	input  phys_idx_t  free_tag1,
	input  arch_map_t  committed_map
);

	phys_mask_t free_mask;	// 1 means tag is free
	phys_mask_t free_mask_next;
	phys_mask_t committed_refs;	// tags held by committed_map
	logic       found0;
	logic       found1;

	////////////////////////////////////////
	// two lowest free tags
	////////////////////////////////////////
	always_comb begin
		alloc_tag0 = '0;
		alloc_tag1 = '0;
		found0     = 1'b0;
		found1     = 1'b0;
		// scan downward, each hit pushes the previous one to second place
		for (int i = phys_regs - 1; i >= 0; i--) begin
			if (free_mask[i]) begin
				alloc_tag1 = alloc_tag0;
				found1     = found0;
				alloc_tag0 = phys_idx_t'(i);
				found0     = 1'b1;
			end
		end
	end

	assign alloc_count = {1'b0, found0} + {1'b0, found1};

	////////////////////////////////////////
	// recovery image
	////////////////////////////////////////
	always_comb begin
		committed_refs = '0;
		for (int a = 0; a < arch_regs; a++) begin
			committed_refs[committed_map[a]] = 1'b1;
		end
	end

	////////////////////////////////////////
	// mask update
	////////////////////////////////////////
	always_comb begin
		free_mask_next = free_mask;
		if (mispredict) begin
			free_mask_next = ~committed_refs;	// everything not committed
		end else begin
			if (alloc_take0) begin
				free_mask_next[alloc_tag0] = 1'b0;
			end
			if (alloc_take1) begin
				free_mask_next[alloc_tag1] = 1'b0;
			end
			// freed tags were mapped, never clash with takes
			if (free_valid[0]) begin
				free_mask_next[free_tag0] = 1'b1;
			end
			if (free_valid[1]) begin
				free_mask_next[free_tag1] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < phys_regs; i++) begin
				free_mask[i] <= (i >= arch_regs);	// upper tags start free
			end
		end else begin
			free_mask <= free_mask_next;
		end
	end

endmodule

// ==== hdl/rename_cfg_pkg.sv ====
package rename_cfg_pkg;

	////////////////////////////////////////
	// subsystem sizes
	////////////////////////////////////////
	localparam int arch_regs    = 32;	// architectural registers
	localparam int phys_regs    = 64;	// physical tags
	localparam int group_width  = 2;	// instructions per rename group
	localparam int retire_width = 2;	// commits per cycle
	localparam int arch_idx_w   = $clog2(arch_regs);
	localparam int phys_idx_w   = $clog2(phys_regs);

	typedef logic [arch_idx_w-1:0]     arch_idx_t;	// arch register index
	typedef logic [phys_idx_w-1:0]     phys_idx_t;	// physical tag
	typedef logic [phys_regs-1:0]      phys_mask_t;	// one bit per tag
	typedef phys_idx_t [arch_regs-1:0] arch_map_t;	// tag per arch register

	// power-up mapping, arch reg i lives in tag i
	function automatic arch_map_t identity_map();
		arch_map_t m;
		for (int i = 0; i < arch_regs; i++) begin
			m[i] = phys_idx_t'(i);
		end
		return m;
	endfunction

endpackage

// ==== hdl/rename_if_pkg.sv ====
package rename_if_pkg;

	import rename_cfg_pkg::*;

	////////////////////////////////////////
	// rename request
	////////////////////////////////////////
	typedef struct packed {
		logic      has_dest;	// slot writes a register
		arch_idx_t dest;
		arch_idx_t src_a;
		arch_idx_t src_b;
	} rename_slot_t;

	typedef rename_slot_t [group_width-1:0] rename_req_t;	// slot 0 is oldest

	////////////////////////////////////////
	// rename response
	////////////////////////////////////////
	typedef struct packed {
		logic      has_dest;
		arch_idx_t dest_arch;
		phys_idx_t dest_phys;	// freshly allocated tag
		phys_idx_t old_phys;	// displaced mapping, freed at retire
		phys_idx_t src_a_phys;
		phys_idx_t src_b_phys;
	} renamed_slot_t;

	typedef renamed_slot_t [group_width-1:0] rename_rsp_t;

	////////////////////////////////////////
	// retire port
	////////////////////////////////////////
	typedef struct packed {
		logic      valid;	// commit this slot
		arch_idx_t dest_arch;
		phys_idx_t dest_phys;
	} retire_slot_t;

	// slot 0 commits before slot 1
	typedef retire_slot_t [retire_width-1:0] retire_req_t;

endpackage

// ==== hdl/rename_map_table.sv ====
module rename_map_table import rename_cfg_pkg::*, rename_if_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        mispredict,	// restore from committed_map
	input  logic        in_valid,
	output logic        in_ready,
	input  rename_req_t in_group,
	output logic        out_valid,
	input  logic        out_ready,
	output rename_rsp_t out_group,
	input  phys_idx_t   alloc_tag0,	// lowest free tag
	input  phys_idx_t   alloc_tag1,	// second lowest free tag
	input  logic [1:0]  alloc_count,	// free tags on offer, 0..2
	output logic        alloc_take0,
	output logic        alloc_take1,
	input  arch_map_t   committed_map
);

	arch_map_t     spec_map;	// speculative alias table
	arch_map_t     spec_map_next;
	rename_slot_t  slot0;
	rename_slot_t  slot1;
	logic [1:0]    demand;	// destinations in the group
	logic          stage_free;
	logic          accept;
	logic          same_dest;
	logic          byp_a;
	logic          byp_b;
	phys_idx_t     new_tag0;
	phys_idx_t     new_tag1;
	renamed_slot_t rsp0;
	renamed_slot_t rsp1;

	assign slot0 = in_group[0];
	assign slot1 = in_group[1];

	////////////////////////////////////////
	// handshake and allocation
	////////////////////////////////////////
	assign demand     = {1'b0, slot0.has_dest} + {1'b0, slot1.has_dest};
	assign stage_free = !out_valid || out_ready;	// output empty or leaving
	// whole group or nothing
	assign in_ready   = stage_free && !mispredict && (demand <= alloc_count);
	assign accept     = in_valid && in_ready;

	assign alloc_take0 = accept && (demand != 2'd0);	// first dest in group
	assign alloc_take1 = accept && (demand == 2'd2);	// both slots write

	assign new_tag0 = alloc_tag0;
	assign new_tag1 = slot0.has_dest ? alloc_tag1 : alloc_tag0;	// slot 0 has first pick

	////////////////////////////////////////
	// lookup with intra-group bypass
	////////////////////////////////////////
	assign same_dest = slot0.has_dest && slot1.has_dest && (slot0.dest == slot1.dest);
	assign byp_a     = slot0.has_dest && (slot0.dest == slot1.src_a);	// raw on src a
	assign byp_b     = slot0.has_dest && (slot0.dest == slot1.src_b);	// raw on src b

	always_comb begin
		rsp0.has_dest   = slot0.has_dest;
		rsp0.dest_arch  = slot0.dest;
		rsp0.dest_phys  = slot0.has_dest ? new_tag0 : '0;
		rsp0.old_phys   = slot0.has_dest ? spec_map[slot0.dest] : '0;
		rsp0.src_a_phys = spec_map[slot0.src_a];
		rsp0.src_b_phys = spec_map[slot0.src_b];

		rsp1.has_dest   = slot1.has_dest;
		rsp1.dest_arch  = slot1.dest;
		rsp1.dest_phys  = slot1.has_dest ? new_tag1 : '0;
		if (!slot1.has_dest) begin
			rsp1.old_phys = '0;
		end else if (same_dest) begin
			rsp1.old_phys = new_tag0;	// displaces slot 0's fresh tag
		end else begin
			rsp1.old_phys = spec_map[slot1.dest];
		end
		rsp1.src_a_phys = byp_a ? new_tag0 : spec_map[slot1.src_a];
		rsp1.src_b_phys = byp_b ? new_tag0 : spec_map[slot1.src_b];
	end

	////////////////////////////////////////
	// speculative map update
	////////////////////////////////////////
	always_comb begin
		spec_map_next = spec_map;
		if (mispredict) begin
			spec_map_next = committed_map;	// full copy of retirement state
		end else if (accept) begin
			if (slot0.has_dest) begin
				spec_map_next[slot0.dest] = new_tag0;
			end
			if (slot1.has_dest) begin
				spec_map_next[slot1.dest] = new_tag1;	// younger wins
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			spec_map <= identity_map();
		end else begin
			spec_map <= spec_map_next;
		end
	end

	////////////////////////////////////////
	// output stage
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (mispredict) begin
			out_valid <= 1'b0;	// flush wrong-path group
		end else if (accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;	// consumed, nothing behind it
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			out_group[0] <= rsp0;
			out_group[1] <= rsp1;
		end
	end

endmodule

// ==== hdl/rename_top.sv ====
module rename_top import rename_cfg_pkg::*, rename_if_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        mispredict,
	input  logic        in_valid,
	output logic        in_ready,
	input  rename_req_t in_group,
	output logic        out_valid,
	input  logic        out_ready,
	output rename_rsp_t out_group,
	input  retire_req_t retire
);

	phys_idx_t  alloc_tag0;	// free list to map table
	phys_idx_t  alloc_tag1;
	logic [1:0] alloc_count;
	logic       alloc_take0;	// map table to free list
	logic       alloc_take1;
	logic [1:0] free_valid;	// retire frees
	phys_idx_t  free_tag0;
	phys_idx_t  free_tag1;
	arch_map_t  committed_map;

	////////////////////////////////////////
	// speculative rename
	////////////////////////////////////////
	rename_map_table map_i (
		.clock         (clock),
		.reset         (reset),
		.mispredict    (mispredict),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_group      (in_group),
		.out_valid     (out_valid),
		.out_ready     (out_ready),
		.out_group     (out_group),
		.alloc_tag0    (alloc_tag0),
		.alloc_tag1    (alloc_tag1),
		.alloc_count   (alloc_count),
		.alloc_take0   (alloc_take0),
		.alloc_take1   (alloc_take1),
		.committed_map (committed_map)
	);

	////////////////////////////////////////
	// committed state
	////////////////////////////////////////
	arch_map_table arch_i (
		.clock         (clock),
		.reset         (reset),
		.mispredict    (mispredict),
		.retire        (retire),
		.committed_map (committed_map),
		.free_valid    (free_valid),
		.free_tag0     (free_tag0),
		.free_tag1     (free_tag1)
	);

	phys_free_list free_i (
		.clock         (clock),
		.reset         (reset),
		.mispredict    (mispredict),
		.alloc_take0   (alloc_take0),
		.alloc_take1   (alloc_take1),
		.alloc_tag0    (alloc_tag0),
		.alloc_tag1    (alloc_tag1),
		.alloc_count   (alloc_count),
		.free_valid    (free_valid),
		.free_tag0     (free_tag0),
		.free_tag1     (free_tag1),
		.committed_map (committed_map)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rename testbench with Verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module rename_tb -f sim.f -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/rename_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$log"; then
	exit 0
fi
exit 1

// ==== sim.f ====
hdl/rename_cfg_pkg.sv
hdl/rename_if_pkg.sv
hdl/rename_map_table.sv
hdl/arch_map_table.sv
hdl/phys_free_list.sv
hdl/rename_top.sv
testbench/rename_sva.sv
testbench/rename_tb.sv

// ==== testbench/rename_sva.sv ====
module rename_sva import rename_cfg_pkg::*, rename_if_pkg::*; (
	input logic        clock,
	input logic        reset,
	input logic        mispredict,
	input logic        in_valid,
	input logic        in_ready,
	input rename_req_t in_group,
	input logic        out_valid,
	input logic        out_ready,
	input rename_rsp_t out_group,
	input logic [1:0]  alloc_count
);

	logic [1:0] demand;	// destinations asked for by the group
	int         fail_count = 0;	// assertion failures so far

	assign demand = {1'b0, in_group[0].has_dest} + {1'b0, in_group[1].has_dest};

	// held output must not change under back-pressure
	output_stable: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready && !mispredict |=> out_valid && $stable(out_group))
		else begin
			$error("out_group changed while stalled");
			fail_count++;
		end

	// wrong-path group is dropped
	flush_clears: assert property (@(posedge clock) disable iff (reset)
		mispredict |=> !out_valid)
		else begin
			$error("out_valid high after mispredict");
			fail_count++;
		end

	// two destinations in one group never share a tag
	distinct_tags: assert property (@(posedge clock) disable iff (reset)
		in_valid && in_ready && (demand == 2'd2)
			|=> out_group[0].dest_phys != out_group[1].dest_phys)
		else begin
			$error("both slots got the same tag");
			fail_count++;
		end

endmodule

bind rename_map_table rename_sva sva_i (.*);

// ==== testbench/rename_tb.sv ====
module rename_tb import rename_cfg_pkg::*, rename_if_pkg::*; ();

	localparam logic [1:0] kind_rename = 2'd0;
	localparam logic [1:0] kind_retire = 2'd1;
	localparam logic [1:0] kind_flush  = 2'd2;
	localparam logic [1:0] kind_drain  = 2'd3;
	localparam logic [6:0] from_model  = 7'h7f;	// field predicted by the model
	localparam int         timeout_cyc = 200;

	typedef struct packed {
		logic [1:0]       kind;
		logic             stall;	// random out_ready while this runs
		rename_req_t      group;
		logic [2:0]       count;	// destinations to retire
		logic [5:0][6:0]  exp;	// a0 b0 a1 b1 d0 d1
	} entry_t;

	logic        clock = 1'b0;
	logic        reset;
	logic        mispredict;
	logic        in_valid;
	logic        in_ready;
	logic        out_valid;
	logic        out_ready;
	rename_req_t in_group;
	rename_rsp_t out_group;
	retire_req_t retire;

	entry_t          table_rom [13];
	arch_map_t       spec_m;	// model alias tables
	arch_map_t       com_m;
	phys_mask_t      free_m;	// model free tags
	rename_rsp_t     exp_q [$];	// groups expected at the output
	retire_slot_t    pend_q [$];	// renamed, not retired
	logic [5:0][6:0] cur_exp;
	logic            stall;
	int              checks;
	int              errors;
	int              outs;
	int              drain_n;

	rename_top dut_i (.*);

	always #4 clock = !clock;

	initial begin
		out_ready = 1'b1;
		void'($urandom(86));
		forever begin
			@(posedge clock);
			out_ready <= stall ? 1'($urandom % 2) : 1'b1;	// random stall pattern
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////
	task automatic check_equal(input logic [63:0] got, input logic [63:0] want, input string msg);
		checks++;
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, got, want);
		end
	endtask

	task automatic abort_timeout(input string what);
		$display("timeout after %0d cycles waiting for %s", timeout_cyc, what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	function automatic rename_slot_t slot(input logic hd, input int d, input int a, input int b);
		return {hd, arch_idx_t'(d), arch_idx_t'(a), arch_idx_t'(b)};
	endfunction

	function automatic int lowest_free(input phys_mask_t m);
		for (int i = 0; i < phys_regs; i++) begin
			if (m[i]) return i;
		end
		return -1;
	endfunction

	function automatic int free_count(input phys_mask_t m);
		int n = 0;
		for (int i = 0; i < phys_regs; i++) n += m[i];
		return n;
	endfunction

	////////////////////////////////////////
	// reference model, sampled mid-cycle
	////////////////////////////////////////
	task automatic model_accept();
		rename_rsp_t r;
		rename_slot_t s;
		int tag;
		for (int i = 0; i < group_width; i++) begin
			s = in_group[i];
			r[i] = '0;
			r[i].has_dest   = s.has_dest;
			r[i].dest_arch  = s.dest;
			r[i].src_a_phys = spec_m[s.src_a];	// slot 0 writes land first, so bypass falls out
			r[i].src_b_phys = spec_m[s.src_b];
			if (s.has_dest) begin
				tag = lowest_free(free_m);
				free_m[tag] = 1'b0;
				r[i].dest_phys = phys_idx_t'(tag);
				r[i].old_phys  = spec_m[s.dest];
				spec_m[s.dest] = phys_idx_t'(tag);
				pend_q.push_back({1'b1, s.dest, phys_idx_t'(tag)});
			end
		end
		// table values override the model where given
		if (cur_exp[0] != from_model) r[0].src_a_phys = cur_exp[0][5:0];
		if (cur_exp[1] != from_model) r[0].src_b_phys = cur_exp[1][5:0];
		if (cur_exp[2] != from_model) r[1].src_a_phys = cur_exp[2][5:0];
		if (cur_exp[3] != from_model) r[1].src_b_phys = cur_exp[3][5:0];
		if (cur_exp[4] != from_model) r[0].dest_phys  = cur_exp[4][5:0];
		if (cur_exp[5] != from_model) r[1].dest_phys  = cur_exp[5][5:0];
		exp_q.push_back(r);
	endtask

	always @(negedge clock) begin
		int need;
		if (reset) begin
			for (int a = 0; a < arch_regs; a++) spec_m[a] = phys_idx_t'(a);
			com_m  = spec_m;
			free_m = {{(phys_regs-arch_regs){1'b1}}, {arch_regs{1'b0}}};
		end else begin
			check_equal(64'(out_valid), 64'(exp_q.size()), "out_valid");	// one stage, one group
			if (out_valid && out_ready) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected output group at time %0t", $time);
				end else begin
					check_equal(64'(out_group[0]), 64'(exp_q[0][0]), "out slot 0");
					check_equal(64'(out_group[1]), 64'(exp_q[0][1]), "out slot 1");
					void'(exp_q.pop_front());
					outs++;
				end
			end
			need = in_group[0].has_dest + in_group[1].has_dest;
			if (in_valid && !mispredict && (!out_valid || out_ready)) begin
				check_equal(64'(in_ready), 64'(need <= free_count(free_m)), "in_ready");
			end
			if (mispredict) begin
				spec_m = com_m;	// retire this cycle is ignored
				free_m = '1;
				for (int a = 0; a < arch_regs; a++) free_m[com_m[a]] = 1'b0;
				exp_q.delete();
				pend_q.delete();
			end else begin
				if (in_valid && in_ready) model_accept();
				for (int k = 0; k < retire_width; k++) begin
					if (retire[k].valid) begin
						free_m[com_m[retire[k].dest_arch]] = 1'b1;	// displaced tag
						com_m[retire[k].dest_arch] = retire[k].dest_phys;
						void'(pend_q.pop_front());
					end
				end
			end
		end
	end

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////
	task automatic wait_ready(input string what);
		int n = 0;
		do begin
			@(negedge clock);
			n++;
		end while (!in_ready && n < timeout_cyc);
		if (!in_ready) abort_timeout(what);
	endtask

	task automatic send_group(input rename_req_t g);
		@(posedge clock);
		in_valid <= 1'b1;
		in_group <= g;
		wait_ready("rename accept");
		@(posedge clock);
		in_valid <= 1'b0;
	endtask

	task automatic retire_oldest(input int n);
		retire_req_t r;
		int left = n;
		while (left > 0) begin
			r = '0;
			if (pend_q.size() == 0) begin
				errors++;
				$display("nothing left to retire at time %0t", $time);
				break;
			end
			r[0] = pend_q[0];
			if (left > 1 && pend_q.size() > 1) r[1] = pend_q[1];
			left -= r[1].valid ? 2 : 1;
			@(posedge clock);
			retire <= r;
			@(negedge clock);
		end
		@(posedge clock);
		retire <= '0;
	endtask

	task automatic drain_to_exhaustion();
		while (free_count(free_m) >= 2) begin
			drain_n++;
			send_group({slot(1, drain_n % 31 + 1, drain_n % 32, 3), slot(1, 20, 1, 2)});
		end
		@(posedge clock);
		in_valid <= 1'b1;	// held until a retire frees tags
		in_group <= {slot(1, 12, 5, 6), slot(1, 11, 5, 0)};
		repeat (3) begin
			@(negedge clock);
			check_equal(64'(in_ready), 64'd0, "in_ready with no free tags");
		end
	endtask

	////////////////////////////////////////
	// stimulus table and main sequence
	////////////////////////////////////////
	function automatic entry_t ren(input rename_slot_t s0, input rename_slot_t s1,
		input logic st, input logic [5:0][6:0] e);
		return {kind_rename, st, s1, s0, 3'd0, e};
	endfunction

	function automatic entry_t op(input logic [1:0] k, input int n);
		return {k, 1'b0, 32'd0, 3'(n), {6{from_model}}};
	endfunction

	initial begin
		logic [1:0] prev_kind;
		int prev_err;
		reset      = 1'b1;
		mispredict = 1'b0;
		in_valid   = 1'b0;
		in_group   = '0;
		retire     = '0;
		stall      = 1'b0;
		cur_exp    = {6{from_model}};
		table_rom[0]  = ren(slot(1, 5, 0, 1), slot(1, 6, 2, 3), 0,
			{7'd33, 7'd32, 7'd3, 7'd2, 7'd1, 7'd0});	// reset mapping
		table_rom[1]  = ren(slot(1, 7, 1, 2), slot(1, 8, 7, 7), 0,
			{7'd35, 7'd34, 7'd34, 7'd34, 7'd2, 7'd1});	// slot 1 reads slot 0
		table_rom[2]  = ren(slot(1, 9, 5, 6), slot(1, 9, 9, 7), 0, {6{from_model}});
		table_rom[3]  = ren(slot(0, 0, 9, 0), slot(1, 10, 9, 5), 0, {6{from_model}});
		table_rom[4]  = ren(slot(1, 11, 10, 9), slot(1, 12, 11, 8), 1, {6{from_model}});
		table_rom[5]  = ren(slot(1, 13, 12, 4), slot(0, 0, 13, 13), 1, {6{from_model}});
		table_rom[6]  = ren(slot(1, 14, 13, 14), slot(1, 15, 14, 14), 1, {6{from_model}});
		table_rom[7]  = op(kind_drain, 0);
		table_rom[8]  = op(kind_retire, 2);	// stalled group proceeds
		table_rom[9]  = op(kind_retire, 3);	// partial retire
		table_rom[10] = op(kind_flush, 0);
		table_rom[11] = ren(slot(1, 5, 5, 6), slot(1, 9, 9, 7), 0, {6{from_model}});
		table_rom[12] = ren(slot(1, 20, 12, 11), slot(1, 21, 20, 1), 1, {6{from_model}});
		repeat (10) @(posedge clock);
		reset <= 1'b0;
		foreach (table_rom[i]) begin
			prev_err = errors;
			cur_exp  = table_rom[i].exp;
			stall    <= table_rom[i].stall;
			prev_kind = table_rom[i].kind;
			case (prev_kind)
				kind_rename: send_group(table_rom[i].group);
				kind_retire: begin
					retire_oldest(table_rom[i].count);
					if (in_valid) begin	// group held since exhaustion
						wait_ready("stalled group");
						@(posedge clock);
						in_valid <= 1'b0;
					end
				end
				kind_flush: begin
					@(posedge clock);
					mispredict <= 1'b1;
					@(posedge clock);
					mispredict <= 1'b0;
				end
				default: drain_to_exhaustion();
			endcase
			$display("test %0d kind %0d: %s", i, prev_kind, (errors == prev_err) ? "ok" : "errors");
		end
		stall <= 1'b0;
		for (int n = 0; exp_q.size() != 0; n++) begin
			@(negedge clock);
			if (n >= timeout_cyc) abort_timeout("output drain");
		end
		repeat (2) @(posedge clock);
		errors += dut_i.map_i.sva_i.fail_count;	// bound assertion failures
		$display("checks %0d errors %0d groups out %0d", checks, errors, outs);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
